// File: adc_acq_pkg.sv
package adc_acq_pkg;

    // sequencer states, one cycle each except the waiting ones
    typedef enum logic [4:0] {
        IDLE           = 5'd0,
        // wait here until a trigger address sits in the trigger FIFO
        WATCH_FOR_TRIG = 5'd1,
        // fill header, once per trigger
        FILL_INIT1     = 5'd2,
        FILL_INIT2     = 5'd3,
        // waveform header and circular buffer setup
        WAVEFORM_INIT1 = 5'd4,
        WAVEFORM_INIT2 = 5'd5,
        WAVEFORM_INIT3 = 5'd6,
        // one 4-word burst of ADC data per pass through RUN1..RUN4
        RUN1           = 5'd7,
        RUN2           = 5'd8,
        RUN3           = 5'd9,
        RUN4           = 5'd10,
        // drain the buffer read latency after the last burst
        WAVEFORM_TST1  = 5'd11,
        WAVEFORM_TST2  = 5'd12,
        // checksum word
        CHECKSUM1      = 5'd13,
        CHECKSUM2      = 5'd14,
        // hold until the DDR3 writer reports done
        DDR3_WAIT      = 5'd15,
        // hold while the trigger stays high so it cannot retrigger
        DONE           = 5'd16
    } acq_state_t;

    // flops on acq_enable0/1 and acq_trig
    localparam int ENABLE_SYNC_STAGES = 4;

    // flops on ddr3_wr_done
    localparam int WR_DONE_SYNC_STAGES = 2;

    // stages between the RUN4 strobe and the delayed valid
    // covers the circular buffer read latency
    localparam int OUT_VALID_DELAY = 2;

    // fill type comes straight from the two enable levels
    localparam int FILL_TYPE_W = 2;

endpackage

// File: adc_acq_input_sync.sv
`timescale 1ns/100ps

module adc_acq_input_sync import adc_acq_pkg::*; (
    input  logic                   clk,
    input  logic                   adc_acq_full_reset,
    input  logic                   acq_enable0,
    input  logic                   acq_enable1,
    input  logic                   acq_trig,
    input  logic                   ddr3_wr_done,
    output logic [FILL_TYPE_W-1:0] fill_type,
    output logic                   mode_enabled,
    output logic                   trig_level,
    output logic                   trig_pulse,
    output logic                   wr_done
);

    // enable chains, bit 0 is the first flop
    logic [ENABLE_SYNC_STAGES-1:0]  en0_sync;
    logic [ENABLE_SYNC_STAGES-1:0]  en1_sync;
    // trigger chain carries one extra stage for edge detect
    logic [ENABLE_SYNC_STAGES:0]    trig_sync;
    logic [WR_DONE_SYNC_STAGES-1:0] wr_done_sync;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            en0_sync     <= '0;
            en1_sync     <= '0;
            trig_sync    <= '0;
            wr_done_sync <= '0;
        end else begin
            en0_sync     <= {en0_sync[ENABLE_SYNC_STAGES-2:0], acq_enable0};
            en1_sync     <= {en1_sync[ENABLE_SYNC_STAGES-2:0], acq_enable1};
            trig_sync    <= {trig_sync[ENABLE_SYNC_STAGES-1:0], acq_trig};
            wr_done_sync <= {wr_done_sync[WR_DONE_SYNC_STAGES-2:0], ddr3_wr_done};
        end
    end

    // last trigger stage feeds the DONE hold in the sequencer
    assign trig_level = trig_sync[ENABLE_SYNC_STAGES-1];
    assign wr_done    = wr_done_sync[WR_DONE_SYNC_STAGES-1];

    // acquisition mode is on whenever either enable is set
    // both low means the channel is stopped
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            mode_enabled <= 1'b0;
            fill_type    <= '0;
        end else begin
            mode_enabled <= en0_sync[ENABLE_SYNC_STAGES-1] | en1_sync[ENABLE_SYNC_STAGES-1];
            fill_type    <= {en1_sync[ENABLE_SYNC_STAGES-1], en0_sync[ENABLE_SYNC_STAGES-1]};
        end
    end

    // rising edge: last stage high, the one after still low
    // triggers only pass while acquisition mode is on
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            trig_pulse <= 1'b0;
        end else begin
            trig_pulse <= trig_level & ~trig_sync[ENABLE_SYNC_STAGES] & mode_enabled;
        end
    end

    // an edge can only be seen for one cycle
    a_trig_pulse_single: assert property (
        @(posedge clk) disable iff (adc_acq_full_reset)
        trig_pulse |=> !trig_pulse
    );

endmodule

// File: adc_acq_sequencer.sv
`timescale 1ns/100ps

module adc_acq_sequencer import adc_acq_pkg::*; (
    input  logic       clk,
    input  logic       adc_acq_full_reset,
    input  logic       mode_enabled,
    input  logic       trig_level,
    input  logic       trig_fifo_empty,
    input  logic       burst_cntr_zero,
    input  logic       wr_done,
    output acq_state_t next_state,
    output logic       acq_enabled
);

    acq_state_t state_q;

    // state register
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= next_state;
        end
    end

    // next-state logic
    always_comb begin
        next_state = state_q;
        case (state_q)
            // armed once either enable is set
            IDLE: begin
                if (mode_enabled) begin
                    next_state = WATCH_FOR_TRIG;
                end
            end
            // DDR3 reads may run while we sit here
            WATCH_FOR_TRIG: begin
                if (!trig_fifo_empty) begin
                    next_state = FILL_INIT1;
                end
            end
            FILL_INIT1:     next_state = FILL_INIT2;
            FILL_INIT2:     next_state = WAVEFORM_INIT1;
            WAVEFORM_INIT1: next_state = WAVEFORM_INIT2;
            WAVEFORM_INIT2: next_state = WAVEFORM_INIT3;
            WAVEFORM_INIT3: next_state = RUN1;
            // two 12-bit samples per 32-bit word, one word per RUN state
            RUN1:           next_state = RUN2;
            RUN2:           next_state = RUN3;
            RUN3:           next_state = RUN4;
            // loop for another burst until the counter runs out
            RUN4: begin
                if (burst_cntr_zero) begin
                    next_state = WAVEFORM_TST1;
                end else begin
                    next_state = RUN1;
                end
            end
            WAVEFORM_TST1:  next_state = WAVEFORM_TST2;
            WAVEFORM_TST2:  next_state = CHECKSUM1;
            CHECKSUM1:      next_state = CHECKSUM2;
            CHECKSUM2:      next_state = DDR3_WAIT;
            // everything is in the FIFO, wait for the DDR3 writer
            DDR3_WAIT: begin
                if (wr_done) begin
                    next_state = DONE;
                end
            end
            // a trigger still held high must not start another fill
            DONE: begin
                if (!(mode_enabled && trig_level)) begin
                    next_state = IDLE;
                end
            end
            default:        next_state = IDLE;
        endcase
    end

    // low while DDR3 may be read (idle or watching)
    // high while a fill is being written, name kept for the DDR3 side
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            acq_enabled <= 1'b0;
        end else begin
            acq_enabled <= !(next_state == IDLE || next_state == WATCH_FOR_TRIG);
        end
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (adc_acq_full_reset)
        !$isunknown(state_q) && (state_q <= DONE)
    );

endmodule

// File: adc_acq_strobe_decode.sv
`timescale 1ns/100ps

module adc_acq_strobe_decode import adc_acq_pkg::*; (
    input  logic       clk,
    input  logic       adc_acq_full_reset,
    input  acq_state_t next_state,
    input  logic       dummy_dat_reset_mode,
    output logic       address_cntr_en,
    output logic       dummy_dat_reset,
    output logic       adc_mux_fill_hdr_sel,
    output logic       adc_mux_wfm_hdr_sel,
    output logic       adc_mux_dat_sel,
    output logic       adc_mux_checksum_select,
    output logic       adc_mux_checksum_update,
    output logic       burst_cntr_init,
    output logic       burst_cntr_en,
    output logic       fill_cntr_en,
    output logic       adc_acq_out_valid,
    output logic       acq_done,
    output logic       sm_idle,
    output logic       init_circ_buf_rd_addr,
    output logic       inc_circ_buf_rd_addr,
    output logic       trig_addr_rd_en,
    output logic       latch_circ_buf_dat
);

    // header and checksum words go straight out
    logic immed_out_valid;
    // burst words wait for the buffer read
    logic start_dlyd_out_valid;
    logic [OUT_VALID_DELAY-1:0] valid_dly;
    logic dlyd_out_valid;

    // strobes are registered from next_state
    // so each one is high in the cycle its state is entered
    always_ff @(posedge clk) begin
        address_cntr_en         <= 1'b0;
        dummy_dat_reset         <= 1'b0;
        adc_mux_fill_hdr_sel    <= 1'b0;
        adc_mux_wfm_hdr_sel     <= 1'b0;
        adc_mux_dat_sel         <= 1'b0;
        adc_mux_checksum_select <= 1'b0;
        burst_cntr_init         <= 1'b0;
        burst_cntr_en           <= 1'b0;
        fill_cntr_en            <= 1'b0;
        immed_out_valid         <= 1'b0;
        start_dlyd_out_valid    <= 1'b0;
        acq_done                <= 1'b0;
        sm_idle                 <= 1'b0;
        init_circ_buf_rd_addr   <= 1'b0;
        inc_circ_buf_rd_addr    <= 1'b0;
        trig_addr_rd_en         <= 1'b0;
        latch_circ_buf_dat      <= 1'b0;
        if (adc_acq_full_reset) begin
            // the sequencer sits in IDLE under reset
            sm_idle <= 1'b1;
        end else begin
            case (next_state)
                // front panel LED status
                IDLE:           sm_idle <= 1'b1;
                FILL_INIT1:     adc_mux_fill_hdr_sel <= 1'b1;
                // fill header into the FIFO, advance the fill address
                FILL_INIT2: begin
                    immed_out_valid <= 1'b1;
                    address_cntr_en <= 1'b1;
                end
                // per-waveform setup
                // the trigger FIFO is first-word-fall-through
                WAVEFORM_INIT1: begin
                    dummy_dat_reset       <= dummy_dat_reset_mode;
                    init_circ_buf_rd_addr <= 1'b1;
                    trig_addr_rd_en       <= 1'b1;
                end
                // waveform header out, load the burst count
                WAVEFORM_INIT2: begin
                    immed_out_valid     <= 1'b1;
                    burst_cntr_init     <= 1'b1;
                    adc_mux_wfm_hdr_sel <= 1'b1;
                end
                // buffer data not ready yet, only step the read address
                WAVEFORM_INIT3: begin
                    address_cntr_en      <= 1'b1;
                    inc_circ_buf_rd_addr <= 1'b1;
                end
                RUN1: begin
                    latch_circ_buf_dat   <= 1'b1;
                    inc_circ_buf_rd_addr <= 1'b1;
                    burst_cntr_en        <= 1'b1;
                    adc_mux_dat_sel      <= 1'b1;
                end
                RUN2, RUN3: begin
                    latch_circ_buf_dat   <= 1'b1;
                    inc_circ_buf_rd_addr <= 1'b1;
                    adc_mux_dat_sel      <= 1'b1;
                end
                // burst complete, its valid goes through the delay line
                RUN4: begin
                    latch_circ_buf_dat   <= 1'b1;
                    start_dlyd_out_valid <= 1'b1;
                    address_cntr_en      <= 1'b1;
                    inc_circ_buf_rd_addr <= 1'b1;
                    adc_mux_dat_sel      <= 1'b1;
                end
                // latch the words still in flight from the buffer
                WAVEFORM_TST1, WAVEFORM_TST2: begin
                    latch_circ_buf_dat <= 1'b1;
                    adc_mux_dat_sel    <= 1'b1;
                end
                CHECKSUM1:      adc_mux_checksum_select <= 1'b1;
                // checksum out, one fill finished
                CHECKSUM2: begin
                    immed_out_valid <= 1'b1;
                    address_cntr_en <= 1'b1;
                    fill_cntr_en    <= 1'b1;
                end
                DONE:           acq_done <= 1'b1;
                default:        ;
            endcase
        end
    end

    assign dlyd_out_valid = valid_dly[OUT_VALID_DELAY-1];

    // delay line for burst valids, then one common output register
    // checksum update rides with the burst valid only
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            valid_dly               <= '0;
            adc_acq_out_valid       <= 1'b0;
            adc_mux_checksum_update <= 1'b0;
        end else begin
            valid_dly               <= {valid_dly[OUT_VALID_DELAY-2:0], start_dlyd_out_valid};
            adc_acq_out_valid       <= immed_out_valid | dlyd_out_valid;
            adc_mux_checksum_update <= dlyd_out_valid;
        end
    end

    a_mux_sel_onehot0: assert property (
        @(posedge clk) disable iff (adc_acq_full_reset)
        $onehot0({adc_mux_fill_hdr_sel, adc_mux_wfm_hdr_sel,
                  adc_mux_dat_sel, adc_mux_checksum_select})
    );

endmodule

// File: adc_acq_sm_cbuf.sv
`timescale 1ns/100ps

module adc_acq_sm_cbuf import adc_acq_pkg::*; (
    // ADC clock domain
    input  logic                   clk,
    input  logic                   adc_acq_full_reset,
    // asynchronous levels from the control side
    input  logic                   acq_enable0,
    input  logic                   acq_enable1,
    input  logic                   acq_trig,
    input  logic                   ddr3_wr_done,
    // same-domain status
    input  logic                   trig_fifo_empty,
    input  logic                   burst_cntr_zero,
    // 0 free-run, 1 reset dummy data every waveform
    input  logic                   dummy_dat_reset_mode,
    output logic [FILL_TYPE_W-1:0] fill_type,
    output logic                   address_cntr_en,
    output logic                   dummy_dat_reset,
    output logic                   adc_mux_fill_hdr_sel,
    output logic                   adc_mux_wfm_hdr_sel,
    output logic                   adc_mux_dat_sel,
    output logic                   adc_mux_checksum_select,
    output logic                   adc_mux_checksum_update,
    output logic                   burst_cntr_init,
    output logic                   burst_cntr_en,
    output logic                   fill_cntr_en,
    output logic                   adc_acq_out_valid,
    output logic                   trig_pulse,
    output logic                   acq_enabled,
    output logic                   acq_done,
    output logic                   init_circ_buf_rd_addr,
    output logic                   inc_circ_buf_rd_addr,
    output logic                   trig_addr_rd_en,
    output logic                   latch_circ_buf_dat,
    output logic                   sm_idle
);

    logic       mode_enabled;
    logic       trig_level;
    logic       wr_done;
    acq_state_t next_state;

    adc_acq_input_sync i_input_sync (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .acq_enable0        (acq_enable0),
        .acq_enable1        (acq_enable1),
        .acq_trig           (acq_trig),
        .ddr3_wr_done       (ddr3_wr_done),
        .fill_type          (fill_type),
        .mode_enabled       (mode_enabled),
        .trig_level         (trig_level),
        .trig_pulse         (trig_pulse),
        .wr_done            (wr_done)
    );

    adc_acq_sequencer i_sequencer (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .mode_enabled       (mode_enabled),
        .trig_level         (trig_level),
        .trig_fifo_empty    (trig_fifo_empty),
        .burst_cntr_zero    (burst_cntr_zero),
        .wr_done            (wr_done),
        .next_state         (next_state),
        .acq_enabled        (acq_enabled)
    );

    adc_acq_strobe_decode i_strobe_decode (
        .clk                     (clk),
        .adc_acq_full_reset      (adc_acq_full_reset),
        .next_state              (next_state),
        .dummy_dat_reset_mode    (dummy_dat_reset_mode),
        .address_cntr_en         (address_cntr_en),
        .dummy_dat_reset         (dummy_dat_reset),
        .adc_mux_fill_hdr_sel    (adc_mux_fill_hdr_sel),
        .adc_mux_wfm_hdr_sel     (adc_mux_wfm_hdr_sel),
        .adc_mux_dat_sel         (adc_mux_dat_sel),
        .adc_mux_checksum_select (adc_mux_checksum_select),
        .adc_mux_checksum_update (adc_mux_checksum_update),
        .burst_cntr_init         (burst_cntr_init),
        .burst_cntr_en           (burst_cntr_en),
        .fill_cntr_en            (fill_cntr_en),
        .adc_acq_out_valid       (adc_acq_out_valid),
        .acq_done                (acq_done),
        .sm_idle                 (sm_idle),
        .init_circ_buf_rd_addr   (init_circ_buf_rd_addr),
        .inc_circ_buf_rd_addr    (inc_circ_buf_rd_addr),
        .trig_addr_rd_en         (trig_addr_rd_en),
        .latch_circ_buf_dat      (latch_circ_buf_dat)
    );

endmodule

// File: tb_adc_acq.sv
`timescale 1ns/100ps

module tb_adc_acq import adc_acq_pkg::*; ();

    localparam int WAIT_LIMIT   = 40;
    localparam int FILL_LIMIT   = 400;
    // cycles after the checksum before ddr3_wr_done is raised
    localparam int WR_DONE_LATE = 12;
    localparam int HOLD_CYCLES  = 10;

    logic clk = 1'b0;
    logic adc_acq_full_reset;
    logic acq_enable0, acq_enable1, acq_trig, ddr3_wr_done;
    logic trig_fifo_empty, burst_cntr_zero, dummy_dat_reset_mode;
    logic [FILL_TYPE_W-1:0] fill_type;
    logic address_cntr_en, dummy_dat_reset, adc_mux_fill_hdr_sel, adc_mux_wfm_hdr_sel;
    logic adc_mux_dat_sel, adc_mux_checksum_select, adc_mux_checksum_update;
    logic burst_cntr_init, burst_cntr_en, fill_cntr_en, adc_acq_out_valid;
    logic trig_pulse, acq_enabled, acq_done, init_circ_buf_rd_addr;
    logic inc_circ_buf_rd_addr, trig_addr_rd_en, latch_circ_buf_dat, sm_idle;

    // burst counter and trigger FIFO models
    logic [3:0]  burst_load = 4'd0;
    logic [3:0]  burst_cnt = 4'd0;
    logic        fifo_arm;
    logic [31:0] lfsr_state = 32'hbf47_9363;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_err_start;
    // counts gathered over one fill
    int n_valid, n_addr, n_burst_en, n_upd, n_upd_bad, n_fill, n_rd;
    int n_done, n_dummy, done_early, idle_early;
    int n_fhdr, n_whdr, n_dsel, n_csel, n_init_rd, n_inc_rd, n_latch;
    int n_en_bad, n_upd_late;

    adc_acq_sm_cbuf i_dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (adc_acq_full_reset) begin
            burst_cnt <= 4'd0;
        end else if (burst_cntr_init) begin
            burst_cnt <= burst_load;
        end else if (burst_cntr_en) begin
            burst_cnt <= burst_cnt - 4'd1;
        end
    end
    assign burst_cntr_zero = (burst_cnt == 4'd0);

    // FWFT flag, armed by a test and cleared by the read strobe
    always @(posedge clk) begin
        if (adc_acq_full_reset) begin
            trig_fifo_empty <= 1'b1;
        end else if (fifo_arm) begin
            trig_fifo_empty <= 1'b0;
        end else if (trig_addr_rd_en) begin
            trig_fifo_empty <= 1'b1;
        end
    end

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    // three LFSR bits give a count of 1 to 8
    task automatic draw_burst_count(output logic [3:0] n);
        logic [2:0] v;
        v = 3'd0;
        for (int i = 0; i < 3; i++) begin
            v = {v[1:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
        n = {1'b0, v} + 4'd1;
    endtask

    task automatic check_val(input string test, input string what, input int exp, input int act);
        if (exp != act) begin
            $display("error %s %s: expected %0d, actual %0d", test, what, exp, act);
            errors++;
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic finish_test(input string test);
        tests_run++;
        if (errors != test_err_start) begin
            tests_failed++;
            $display("%s: failed with %0d errors", test, errors - test_err_start);
        end else begin
            $display("%s: ok", test);
        end
    endtask

    // returns the cycles until fill_type shows the new pair
    task automatic set_enables(input logic [1:0] pair, output int latency);
        bit seen;
        seen = 1'b0;
        latency = -1;
        @(posedge clk);
        acq_enable0 <= pair[0];
        acq_enable1 <= pair[1];
        for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
            @(negedge clk);
            if (acq_enabled) begin
                $display("error enables: acq_enabled high with empty trigger FIFO");
                errors++;
            end
            if (fill_type == pair) begin
                seen = 1'b1;
                latency = i;
            end
        end
        if (!seen) abort_on_timeout("fill_type never followed the enables");
    endtask

    task automatic test_reset_state();
        test_err_start = errors;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_val("reset_state", "sm_idle", 1, int'(sm_idle));
            check_val("reset_state", "acq_enabled", 0, int'(acq_enabled));
            check_val("reset_state", "adc_acq_out_valid", 0, int'(adc_acq_out_valid));
            check_val("reset_state", "trig_pulse", 0, int'(trig_pulse));
            check_val("reset_state", "acq_done", 0, int'(acq_done));
        end
        finish_test("reset_state");
    endtask

    task automatic test_fill_type();
        int lat;
        test_err_start = errors;
        for (int p = 1; p < 4; p++) begin
            set_enables(2'(p), lat);
            check_val("fill_type", "latency", ENABLE_SYNC_STAGES + 1, lat);
            repeat (4) @(negedge clk);
            check_val("fill_type", "acq_enabled", 0, int'(acq_enabled));
        end
        finish_test("fill_type");
    endtask

    // counts pulses over 20 cycles after a rising trigger
    task automatic trig_edge(output int pulses, output int first_at);
        pulses = 0;
        first_at = -1;
        @(posedge clk);
        acq_trig <= 1'b1;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (trig_pulse) begin
                pulses++;
                if (first_at < 0) first_at = i;
            end
        end
        @(posedge clk);
        acq_trig <= 1'b0;
        repeat (8) @(posedge clk);
    endtask

    task automatic test_trig_pulse();
        int pulses, at, lat;
        test_err_start = errors;
        trig_edge(pulses, at);
        check_val("trig_pulse", "pulse count", 1, pulses);
        check_val("trig_pulse", "pulse delay", ENABLE_SYNC_STAGES + 1, at);
        set_enables(2'b00, lat);
        repeat (4) @(posedge clk);
        trig_edge(pulses, at);
        check_val("trig_pulse", "pulses while disabled", 0, pulses);
        set_enables(2'b11, lat);
        finish_test("trig_pulse");
    endtask

    task automatic run_fill(input logic [3:0] n, input bit hold_trig, input bit dummy_mode);
        int since_fill, hold_cnt;
        bit fill_seen, done_seen, wr_raised, finished, set_wr, drop_trig;
        // bit k set when RUN1 was entered k+1 cycles ago
        logic [7:0] run1_hist;
        {n_valid, n_addr, n_burst_en, n_upd, n_upd_bad} = '0;
        {n_fill, n_rd, n_done, n_dummy, done_early, idle_early} = '0;
        {n_fhdr, n_whdr, n_dsel, n_csel, n_init_rd} = '0;
        {n_inc_rd, n_latch, n_en_bad, n_upd_late} = '0;
        {fill_seen, done_seen, wr_raised, finished} = '0;
        run1_hist = '0;
        since_fill = 0;
        hold_cnt = 0;
        @(posedge clk);
        burst_load <= n;
        dummy_dat_reset_mode <= dummy_mode;
        fifo_arm <= 1'b1;
        if (hold_trig) acq_trig <= 1'b1;
        @(posedge clk);
        fifo_arm <= 1'b0;
        for (int i = 0; i < FILL_LIMIT && !finished; i++) begin
            @(negedge clk);
            n_valid    += int'(adc_acq_out_valid);
            n_addr     += int'(address_cntr_en);
            n_burst_en += int'(burst_cntr_en);
            n_upd      += int'(adc_mux_checksum_update);
            n_fill     += int'(fill_cntr_en);
            n_rd       += int'(trig_addr_rd_en);
            n_dummy    += int'(dummy_dat_reset);
            n_fhdr     += int'(adc_mux_fill_hdr_sel);
            n_whdr     += int'(adc_mux_wfm_hdr_sel);
            n_dsel     += int'(adc_mux_dat_sel);
            n_csel     += int'(adc_mux_checksum_select);
            n_init_rd  += int'(init_circ_buf_rd_addr);
            n_inc_rd   += int'(inc_circ_buf_rd_addr);
            n_latch    += int'(latch_circ_buf_dat);
            if (adc_mux_checksum_update && !adc_acq_out_valid) n_upd_bad++;
            // fill strobes only come while the fill owns the DDR3 side
            if ((address_cntr_en || acq_done) && !acq_enabled) n_en_bad++;
            // burst valid lands three RUN cycles plus the delay line after RUN1
            if (adc_mux_checksum_update && !run1_hist[OUT_VALID_DELAY+3]) n_upd_late++;
            run1_hist = {run1_hist[6:0], burst_cntr_en};
            if (fill_cntr_en) fill_seen = 1'b1;
            if (acq_done) begin
                n_done++;
                done_seen = 1'b1;
                if (!wr_raised) done_early++;
            end
            // while the trigger is held the sequencer must stay out of IDLE
            if (sm_idle && hold_trig && acq_trig) idle_early++;
            if (done_seen && sm_idle) finished = 1'b1;
            set_wr = 1'b0;
            drop_trig = 1'b0;
            if (fill_seen && !wr_raised) begin
                since_fill++;
                set_wr = (since_fill == WR_DONE_LATE);
            end
            if (hold_trig && done_seen && acq_trig) begin
                hold_cnt++;
                drop_trig = (hold_cnt == HOLD_CYCLES);
            end
            if (set_wr || drop_trig) begin
                @(posedge clk);
                if (set_wr) begin
                    ddr3_wr_done <= 1'b1;
                    wr_raised = 1'b1;
                end
                if (drop_trig) acq_trig <= 1'b0;
            end
        end
        if (!finished) abort_on_timeout("fill never returned to idle");
        @(posedge clk);
        ddr3_wr_done <= 1'b0;
        acq_trig <= 1'b0;
        repeat (6) @(posedge clk);
    endtask

    task automatic test_full_fill();
        logic [3:0] n;
        int nb;
        test_err_start = errors;
        draw_burst_count(n);
        nb = int'(n);
        run_fill(n, 1'b0, 1'b0);
        check_val("full_fill", "out_valid cycles", nb + 3, n_valid);
        check_val("full_fill", "address_cntr_en", nb + 3, n_addr);
        check_val("full_fill", "burst_cntr_en", nb, n_burst_en);
        check_val("full_fill", "checksum_update", nb, n_upd);
        check_val("full_fill", "update without valid", 0, n_upd_bad);
        check_val("full_fill", "burst valid off its RUN1", 0, n_upd_late);
        check_val("full_fill", "fill_cntr_en", 1, n_fill);
        check_val("full_fill", "trig_addr_rd_en", 1, n_rd);
        check_val("full_fill", "fill_hdr_sel", 1, n_fhdr);
        check_val("full_fill", "wfm_hdr_sel", 1, n_whdr);
        check_val("full_fill", "checksum_select", 1, n_csel);
        // four RUN words per burst plus the two drain states
        check_val("full_fill", "dat_sel", 4 * nb + 2, n_dsel);
        check_val("full_fill", "latch_circ_buf_dat", 4 * nb + 2, n_latch);
        check_val("full_fill", "init_circ_buf_rd_addr", 1, n_init_rd);
        // one read step ahead of the first burst, then one per RUN word
        check_val("full_fill", "inc_circ_buf_rd_addr", 4 * nb + 1, n_inc_rd);
        check_val("full_fill", "strobes with acq_enabled low", 0, n_en_bad);
        check_val("full_fill", "acq_done pulses", 1, n_done);
        check_val("full_fill", "acq_done before wr_done", 0, done_early);
        finish_test("full_fill");
    endtask

    task automatic test_done_hold();
        logic [3:0] n;
        test_err_start = errors;
        draw_burst_count(n);
        run_fill(n, 1'b1, 1'b0);
        check_val("done_hold", "idle while trigger held", 0, idle_early);
        check_val("done_hold", "fill_cntr_en", 1, n_fill);
        finish_test("done_hold");
    endtask

    task automatic test_dummy_reset();
        logic [3:0] n;
        test_err_start = errors;
        draw_burst_count(n);
        run_fill(n, 1'b0, 1'b1);
        check_val("dummy_reset", "pulses in mode 1", 1, n_dummy);
        draw_burst_count(n);
        run_fill(n, 1'b0, 1'b0);
        check_val("dummy_reset", "pulses in mode 0", 0, n_dummy);
        finish_test("dummy_reset");
    endtask

    initial begin
        adc_acq_full_reset = 1'b1;
        acq_enable0 = 1'b0;
        acq_enable1 = 1'b0;
        acq_trig = 1'b0;
        ddr3_wr_done = 1'b0;
        dummy_dat_reset_mode = 1'b0;
        fifo_arm = 1'b0;
        repeat (10) @(posedge clk);
        adc_acq_full_reset <= 1'b0;
        test_reset_state();
        test_fill_type();
        test_trig_pulse();
        test_full_fill();
        test_done_hold();
        test_dummy_reset();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
adc_acq_pkg.sv
adc_acq_input_sync.sv
adc_acq_sequencer.sv
adc_acq_strobe_decode.sv
adc_acq_sm_cbuf.sv
tb_adc_acq.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_adc_acq
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /^TEST RESULT: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
